//--- tau_pkg.sv
// Sizes, lane-index widths and the payload structs of the warp-looping front
// Command, warp, vector and configuration table types
package tau_pkg;

	// ========================================
	// Sizes
	// ========================================

	// Configurations held in the step table
	localparam int N_CFG = 2;
	// Block dimensions
	localparam int VDIM = 2;
	// Lanes per warp
	localparam int VSIZE = 8;
	// Lane-index bits
	localparam int CV_BW = $clog2(VSIZE);
	// Low order range is 0 to CV_BW
	localparam int CCV_BW = $clog2(CV_BW + 1);
	// Work offset width
	localparam int WBW = 10;
	// Global address width
	localparam int ABW = 16;
	// Configuration id width
	localparam int NCFG_BW = $clog2(N_CFG);

	// ========================================
	// Scalar and array types
	// ========================================

	typedef logic [NCFG_BW-1:0] cfg_id_t;
	typedef logic [ABW-1:0]     addr_t;
	typedef logic [WBW-1:0]     wofs_t;
	typedef logic [CCV_BW-1:0]  lo_order_t;

	// One offset per dimension, index 0 is the fast dimension
	typedef wofs_t [VDIM-1:0] bofs_t;
	// Per-lane offsets
	typedef bofs_t [VSIZE-1:0] vbofs_t;
	// Per-lane addresses
	typedef addr_t [VSIZE-1:0] vaddr_t;
	// Address step per lane-index bit
	typedef addr_t [CV_BW-1:0] mofs_steps_t;
	// Step sets of all configurations
	typedef mofs_steps_t [N_CFG-1:0] mofs_tab_t;

	// ========================================
	// Payload structs
	// ========================================

	// Tile command
	typedef struct packed {
		cfg_id_t   id;
		addr_t     linear;
		bofs_t     bboundary;
		addr_t     col_step;
		addr_t     row_step;
		lo_order_t lo_order;
	} cmd_t;

	// One warp handed from the looper to the vector stage
	typedef struct packed {
		cfg_id_t   id;
		addr_t     linear;
		bofs_t     bofs;
		lo_order_t lo_order;
		bofs_t     bboundary;
		logic      retire;
		logic      islast;
	} warp_t;

	// Expanded vector of lane addresses
	typedef struct packed {
		cfg_id_t           id;
		vaddr_t            address;
		logic [VSIZE-1:0]  valid;
		logic              retire;
	} vec_t;

endpackage

//--- rdyack_slice.sv
// One-entry ready/acknowledge pipeline register
// Payload type is set per instance
module rdyack_slice #(
	parameter type payload_t = logic
) (
	input  logic     i_clk,
	input  logic     i_arst_n,
	// Upstream side
	input  logic     i_src_rdy,
	output logic     o_src_ack,
	input  payload_t i_src_data,
	// Downstream side
	output logic     o_dst_rdy,
	input  logic     i_dst_ack,
	output payload_t o_dst_data
);

	// Take a new item when empty or drained in this cycle
	assign o_src_ack = i_src_rdy && (!o_dst_rdy || i_dst_ack);

	// Occupancy flag doubles as downstream ready
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_dst_rdy <= 1'b0;
		end else if (o_src_ack) begin
			o_dst_rdy <= 1'b1;
		end else if (i_dst_ack) begin
			o_dst_rdy <= 1'b0;
		end
	end

	// Payload holds while waiting for ack
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_dst_data <= '0;
		end else if (o_src_ack) begin
			o_dst_data <= i_src_data;
		end
	end

endmodule

//--- bofs_expand.sv
// Expansion of a warp block offset into per-lane offsets
// Lane valid bits from the block boundary
module bofs_expand (
	input  tau_pkg::bofs_t            i_bofs,
	input  tau_pkg::bofs_t            i_bboundary,
	input  tau_pkg::lo_order_t        i_lo_order,
	output tau_pkg::vbofs_t           o_vector_bofs,
	output logic [tau_pkg::VSIZE-1:0] o_valid
);

	// Lane-index bits that belong to dimension 0
	logic [tau_pkg::CV_BW-1:0] lo_mask;

	// Boundaries widened by one bit for the compare
	logic [tau_pkg::WBW:0] bnd0;
	logic [tau_pkg::WBW:0] bnd1;

	assign lo_mask = ~({tau_pkg::CV_BW{1'b1}} << i_lo_order);
	assign bnd0    = {1'b0, i_bboundary[0]};
	assign bnd1    = {1'b0, i_bboundary[1]};

	for (genvar i = 0; i < tau_pkg::VSIZE; i++) begin : g_lane
		localparam logic [tau_pkg::CV_BW-1:0] LANE = i;

		// Sub-offsets inside the warp
		logic [tau_pkg::CV_BW-1:0] sub0;
		logic [tau_pkg::CV_BW-1:0] sub1;
		// Lane offsets with a carry bit
		logic [tau_pkg::WBW:0] ofs0;
		logic [tau_pkg::WBW:0] ofs1;

		// Low bits step dimension 0, high bits step dimension 1
		assign sub0 = LANE & lo_mask;
		assign sub1 = LANE >> i_lo_order;

		assign ofs0 = {1'b0, i_bofs[0]} + {{(tau_pkg::WBW + 1 - tau_pkg::CV_BW){1'b0}}, sub0};
		assign ofs1 = {1'b0, i_bofs[1]} + {{(tau_pkg::WBW + 1 - tau_pkg::CV_BW){1'b0}}, sub1};

		assign o_vector_bofs[i][0] = ofs0[tau_pkg::WBW-1:0];
		assign o_vector_bofs[i][1] = ofs1[tau_pkg::WBW-1:0];

		// Inside the block in both dimensions
		assign o_valid[i] = (ofs0 < bnd0) && (ofs1 < bnd1);
	end

endmodule

//--- accum_warp_looper.sv
// Warp looper over a tile command
// Marks row ends with retire and the final warp with is-last
module accum_warp_looper (
	input  logic           i_clk,
	input  logic           i_arst_n,
	// Tile command
	input  logic           i_cmd_rdy,
	output logic           o_cmd_ack,
	input  tau_pkg::cmd_t  i_cmd,
	// Warp output
	output logic           o_warp_rdy,
	input  logic           i_warp_ack,
	output tau_pkg::warp_t o_warp
);

	// ========================================
	// Tile state
	// ========================================

	logic           busy_r;
	tau_pkg::cmd_t  cmd_r;
	tau_pkg::wofs_t ofs0_r;
	tau_pkg::wofs_t ofs1_r;
	tau_pkg::addr_t linear_r;
	tau_pkg::addr_t row_base_r;

	// Current warp, taken from the command when idle
	tau_pkg::cmd_t  cur_cmd;
	tau_pkg::wofs_t cur_ofs0;
	tau_pkg::wofs_t cur_ofs1;
	tau_pkg::addr_t cur_linear;
	tau_pkg::addr_t cur_row_base;

	// Stepping
	tau_pkg::lo_order_t    lo_hi;
	logic [tau_pkg::WBW:0] step0;
	logic [tau_pkg::WBW:0] step1;
	logic [tau_pkg::WBW:0] nxt_ofs0;
	logic [tau_pkg::WBW:0] nxt_ofs1;
	logic                  row_end;
	logic                  tile_end;

	// Generator side of the output slice
	logic           gen_rdy;
	logic           gen_ack;
	tau_pkg::warp_t gen_warp;

	// ========================================
	// Combinational
	// ========================================

	// First warp comes straight from the command
	always_comb begin
		if (busy_r) begin
			cur_cmd      = cmd_r;
			cur_ofs0     = ofs0_r;
			cur_ofs1     = ofs1_r;
			cur_linear   = linear_r;
			cur_row_base = row_base_r;
		end else begin
			cur_cmd      = i_cmd;
			cur_ofs0     = '0;
			cur_ofs1     = '0;
			cur_linear   = i_cmd.linear;
			cur_row_base = i_cmd.linear;
		end
	end

	// Warp footprint is 2^lo by 2^(3-lo)
	assign lo_hi = tau_pkg::lo_order_t'(tau_pkg::CV_BW) - cur_cmd.lo_order;
	assign step0 = (tau_pkg::WBW + 1)'(1) << cur_cmd.lo_order;
	assign step1 = (tau_pkg::WBW + 1)'(1) << lo_hi;

	assign nxt_ofs0 = {1'b0, cur_ofs0} + step0;
	assign nxt_ofs1 = {1'b0, cur_ofs1} + step1;

	// Row and tile end when the next offset reaches the boundary
	assign row_end  = nxt_ofs0 >= {1'b0, cur_cmd.bboundary[0]};
	assign tile_end = row_end && (nxt_ofs1 >= {1'b0, cur_cmd.bboundary[1]});

	always_comb begin
		gen_warp.id        = cur_cmd.id;
		gen_warp.linear    = cur_linear;
		gen_warp.bofs[0]   = cur_ofs0;
		gen_warp.bofs[1]   = cur_ofs1;
		gen_warp.lo_order  = cur_cmd.lo_order;
		gen_warp.bboundary = cur_cmd.bboundary;
		gen_warp.retire    = row_end;
		gen_warp.islast    = tile_end;
	end

	// A waiting command offers its first warp only when idle
	assign gen_rdy   = busy_r || i_cmd_rdy;
	assign o_cmd_ack = gen_ack && !busy_r;

	rdyack_slice #(
		.payload_t(tau_pkg::warp_t)
	) u_slice (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_src_rdy (gen_rdy),
		.o_src_ack (gen_ack),
		.i_src_data(gen_warp),
		.o_dst_rdy (o_warp_rdy),
		.i_dst_ack (i_warp_ack),
		.o_dst_data(o_warp)
	);

	// ========================================
	// Sequential
	// ========================================

	// Counters advance once per warp handed to the slice
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy_r     <= 1'b0;
			ofs0_r     <= '0;
			ofs1_r     <= '0;
			linear_r   <= '0;
			row_base_r <= '0;
		end else if (gen_ack) begin
			busy_r <= !tile_end;
			if (row_end) begin
				// Back to column 0 of the next row
				ofs0_r     <= '0;
				ofs1_r     <= nxt_ofs1[tau_pkg::WBW-1:0];
				row_base_r <= cur_row_base + cur_cmd.row_step;
				linear_r   <= cur_row_base + cur_cmd.row_step;
			end else begin
				ofs0_r     <= nxt_ofs0[tau_pkg::WBW-1:0];
				ofs1_r     <= cur_ofs1;
				row_base_r <= cur_row_base;
				linear_r   <= cur_linear + cur_cmd.col_step;
			end
		end
	end

	// Command fields kept for the rest of the tile
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cmd_r <= '0;
		end else if (o_cmd_ack) begin
			cmd_r <= i_cmd;
		end
	end

endmodule

//--- accum_warp_vector_stage.sv
// Warp to vector stage with lane addresses and lane valids
// Finish pulse on the ack of the last vector
module accum_warp_vector_stage (
	input  logic               i_clk,
	input  logic               i_arst_n,
	// Warp input
	input  logic               i_src_rdy,
	output logic               o_src_ack,
	input  tau_pkg::warp_t     i_warp,
	// Static step table
	input  tau_pkg::mofs_tab_t i_mofs_tab,
	// Vector output
	output logic               o_dst_rdy,
	input  logic               i_dst_ack,
	output tau_pkg::vec_t      o_vec,
	// Tile done
	output logic               o_fin_dval
);

	// Steps of the selected configuration
	tau_pkg::mofs_steps_t mofs_step;
	// Unregistered vector
	tau_pkg::vaddr_t           address_w;
	logic [tau_pkg::VSIZE-1:0] valid_w;
	tau_pkg::vec_t             vec_w;
	// Last flag of the held vector
	logic                      islast_r;

	// ========================================
	// Lane expansion
	// ========================================

	bofs_expand u_bexp (
		.i_bofs       (i_warp.bofs),
		.i_bboundary  (i_warp.bboundary),
		.i_lo_order   (i_warp.lo_order),
		.o_vector_bofs(),
		.o_valid      (valid_w)
	);

	assign mofs_step = i_mofs_tab[i_warp.id];

	// Lane address is linear plus one step per set index bit
	always_comb begin
		for (int i = 0; i < tau_pkg::VSIZE; i++) begin
			address_w[i] = i_warp.linear;
			for (int j = 0; j < tau_pkg::CV_BW; j++) begin
				if (((i >> j) & 1) != 0) begin
					address_w[i] = address_w[i] + mofs_step[j];
				end
			end
		end
	end

	always_comb begin
		vec_w.id      = i_warp.id;
		vec_w.address = address_w;
		vec_w.valid   = valid_w;
		vec_w.retire  = i_warp.retire;
	end

	// ========================================
	// Output register
	// ========================================

	rdyack_slice #(
		.payload_t(tau_pkg::vec_t)
	) u_slice (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_src_rdy (i_src_rdy),
		.o_src_ack (o_src_ack),
		.i_src_data(vec_w),
		.o_dst_rdy (o_dst_rdy),
		.i_dst_ack (i_dst_ack),
		.o_dst_data(o_vec)
	);

	// Loaded together with the slice
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			islast_r <= 1'b0;
		end else if (o_src_ack) begin
			islast_r <= i_warp.islast;
		end
	end

	// Fires as the last vector leaves
	assign o_fin_dval = i_dst_ack && islast_r;

endmodule

//--- accum_warp_top.sv
// Warp-looping front top with looper and vector stage
module accum_warp_top (
	input  logic               i_clk,
	input  logic               i_arst_n,
	// Tile command
	input  logic               i_cmd_rdy,
	output logic               o_cmd_ack,
	input  tau_pkg::cmd_t      i_cmd,
	// Static step table
	input  tau_pkg::mofs_tab_t i_mofs_tab,
	// Vector output
	output logic               o_dst_rdy,
	input  logic               i_dst_ack,
	output tau_pkg::vec_t      o_vec,
	// Tile done
	output logic               o_fin_dval
);

	// Looper to vector stage link
	logic           warp_rdy;
	logic           warp_ack;
	tau_pkg::warp_t warp;

	// Warp generation
	accum_warp_looper u_looper (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_cmd_rdy (i_cmd_rdy),
		.o_cmd_ack (o_cmd_ack),
		.i_cmd     (i_cmd),
		.o_warp_rdy(warp_rdy),
		.i_warp_ack(warp_ack),
		.o_warp    (warp)
	);

	// Lane address expansion
	accum_warp_vector_stage u_vstage (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_src_rdy (warp_rdy),
		.o_src_ack (warp_ack),
		.i_warp    (warp),
		.i_mofs_tab(i_mofs_tab),
		.o_dst_rdy (o_dst_rdy),
		.i_dst_ack (i_dst_ack),
		.o_vec     (o_vec),
		.o_fin_dval(o_fin_dval)
	);

endmodule

//--- tb_clk_gen.sv
// Testbench clock and reset source
module tb_clk_gen (
	output logic o_clk,
	output logic o_arst_n
);

	localparam int HALF_PERIOD = 2;
	localparam int RST_CYCLES = 16;

	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	// Release just after a rising edge
	initial begin
		o_arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		#1;
		o_arst_n = 1'b1;
	end

endmodule

//--- tb_accum_warp_chk.sv
// Bind checker for the warp-looping front
// Reset, reference vector, hold, finish pulse and latency assertions
module tb_accum_warp_chk (
	input logic          i_clk,
	input logic          i_arst_n,
	input logic          i_cmd_ack,
	input logic          i_dst_rdy,
	input logic          i_dst_ack,
	input logic          i_fin_dval,
	input tau_pkg::vec_t i_vec,
	// Looper generator handshake
	input logic          i_gen_ack,
	// Reference head from the testbench
	input tau_pkg::vec_t i_exp_vec,
	input logic          i_exp_avail,
	input logic          i_exp_last,
	input logic          i_ack_always,
	// Warps of all commands taken so far, from the reference
	input int            i_exp_issued
);

	// Failed assertions so far
	int n_fail = 0;
	// Warps handed to the looper output slice since reset
	int n_issued;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			n_issued <= 0;
		end else if (i_gen_ack) begin
			n_issued <= n_issued + 1;
		end
	end

	// ========================================
	// Assertions
	// ========================================

	a_reset_quiet: assert property (@(posedge i_clk)
		!i_arst_n |-> !i_cmd_ack && !i_dst_rdy && !i_fin_dval && (i_vec == '0))
	else begin
		$error("Outputs active or vector payload not zero during reset");
		n_fail++;
	end

	// Every transfer against the reference head
	a_vec_ref: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_dst_rdy && i_dst_ack |-> i_exp_avail && (i_vec == i_exp_vec))
	else begin
		$error("Mismatch at time %0t: vector %h, expected %h", $time,
			$sampled(i_vec), $sampled(i_exp_vec));
		n_fail++;
	end

	a_vec_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_dst_rdy && !i_dst_ack |=> i_dst_rdy && $stable(i_vec))
	else begin
		$error("Vector dropped or changed while waiting for ack");
		n_fail++;
	end

	// Finish exactly with the ack of the last vector
	a_fin_last: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_fin_dval == (i_dst_rdy && i_dst_ack && i_exp_last))
	else begin
		$error("Finish pulse not aligned with the last vector");
		n_fail++;
	end

	// All warps of the earlier tiles issued when a new command is taken
	a_one_tile: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_cmd_ack |-> (n_issued == i_exp_issued))
	else begin
		$error("Command taken before all warps of the earlier tiles were issued");
		n_fail++;
	end

	// Latency and throughput without back-pressure
	a_first_lat: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_ack_always && i_cmd_ack |-> ##2 i_dst_rdy)
	else begin
		$error("First vector not ready two cycles after the command ack");
		n_fail++;
	end

	a_streaming: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_ack_always && i_dst_rdy && i_dst_ack && !i_fin_dval |=> i_dst_rdy)
	else begin
		$error("Gap in the vector stream inside a tile");
		n_fail++;
	end

endmodule

//--- tb_accum_warp.sv
// Testbench top for the warp-looping front
// Random tile commands, reference queue, ack gaps, watchdog and closing report
module tb_accum_warp;

	// ========================================
	// Constants and signals
	// ========================================

	localparam int N_CMD = 24;
	// Opening commands run with an ack for every ready vector
	localparam int N_ALWAYS = 8;
	localparam int MAX_BND = 20;
	// Most warps of one tile, reached at low order 0
	localparam int MAX_WARPS = MAX_BND * ((MAX_BND + 7) / 8);
	localparam int WATCHDOG_CYCLES = 16 + N_CMD * MAX_WARPS * 20;
	// Length of the repeating ack gap pattern
	localparam int ACK_PAT_LEN = 256;

	logic               clk;
	logic               arst_n;
	logic               cmd_rdy;
	logic               cmd_ack;
	tau_pkg::cmd_t      cmd;
	tau_pkg::mofs_tab_t mofs_tab;
	logic               dst_rdy;
	logic               dst_ack;
	tau_pkg::vec_t      vec;
	logic               fin_dval;

	// Head of the reference queue, seen by the checker
	tau_pkg::vec_t exp_head;
	logic          exp_avail;
	logic          exp_last;
	logic          ack_always;
	// Expected warps of all commands taken so far
	int            exp_issued;
	int            n_acked;

	tau_pkg::cmd_t cmd_list [N_CMD];
	tau_pkg::vec_t exp_q [$];
	logic          last_q [$];
	// Running total of expected vectors after each command
	int            n_exp [N_CMD];
	int            n_vec;
	int            n_fin;
	int            err_cnt;

	// Cycles in which the ack is held back outside streaming
	logic          hold_pat [ACK_PAT_LEN];
	int            ack_idx;

	tb_clk_gen u_clk (
		.o_clk   (clk),
		.o_arst_n(arst_n)
	);

	accum_warp_top u_dut (
		.i_clk     (clk),
		.i_arst_n  (arst_n),
		.i_cmd_rdy (cmd_rdy),
		.o_cmd_ack (cmd_ack),
		.i_cmd     (cmd),
		.i_mofs_tab(mofs_tab),
		.o_dst_rdy (dst_rdy),
		.i_dst_ack (dst_ack),
		.o_vec     (vec),
		.o_fin_dval(fin_dval)
	);

	bind accum_warp_top tb_accum_warp_chk u_chk (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_cmd_ack   (o_cmd_ack),
		.i_dst_rdy   (o_dst_rdy),
		.i_dst_ack   (i_dst_ack),
		.i_fin_dval  (o_fin_dval),
		.i_vec       (o_vec),
		.i_gen_ack   (u_looper.gen_ack),
		.i_exp_vec   (tb_accum_warp.exp_head),
		.i_exp_avail (tb_accum_warp.exp_avail),
		.i_exp_last  (tb_accum_warp.exp_last),
		.i_ack_always(tb_accum_warp.ack_always),
		.i_exp_issued(tb_accum_warp.exp_issued)
	);

	// ========================================
	// Reference model
	// ========================================

	// Table steps picked by the set bits of a lane index
	function automatic tau_pkg::addr_t lane_step(input int id, input int lane);
		tau_pkg::addr_t sum;
		sum = '0;
		for (int j = 0; j < tau_pkg::CV_BW; j++) begin
			if ((lane >> j) % 2 == 1) begin
				sum = sum + mofs_tab[id][j];
			end
		end
		return sum;
	endfunction

	// Opening commands sweep low orders 0, 1 and 3 over both configurations
	function automatic tau_pkg::cmd_t make_cmd(input int idx);
		tau_pkg::cmd_t c;
		int            lo;
		if (idx < 6) begin
			lo   = (idx % 3 == 2) ? 3 : idx % 3;
			c.id = tau_pkg::cfg_id_t'(idx / 3);
		end else begin
			lo   = $urandom % 4;
			c.id = tau_pkg::cfg_id_t'($urandom % tau_pkg::N_CFG);
		end
		c.lo_order     = tau_pkg::lo_order_t'(lo);
		c.linear       = tau_pkg::addr_t'($urandom);
		c.bboundary[0] = tau_pkg::wofs_t'(1 + $urandom % MAX_BND);
		c.bboundary[1] = tau_pkg::wofs_t'(1 + $urandom % MAX_BND);
		c.col_step     = tau_pkg::addr_t'($urandom);
		c.row_step     = tau_pkg::addr_t'($urandom);
		return c;
	endfunction

	// Warp footprint is s0 lanes wide and s1 lanes high
	task automatic build_reference(input tau_pkg::cmd_t c);
		tau_pkg::vec_t  v;
		tau_pkg::addr_t row_base;
		tau_pkg::addr_t lin;
		int             s0;
		int             s1;
		int             o0;
		int             o1;
		logic           row_end;
		logic           tile_end;
		s0       = 1 << c.lo_order;
		s1       = tau_pkg::VSIZE / s0;
		row_base = c.linear;
		o1       = 0;
		tile_end = 1'b0;
		while (!tile_end) begin
			o0      = 0;
			lin     = row_base;
			row_end = 1'b0;
			while (!row_end) begin
				row_end  = o0 + s0 >= c.bboundary[0];
				tile_end = row_end && (o1 + s1 >= c.bboundary[1]);
				v.id     = c.id;
				v.retire = row_end;
				for (int k = 0; k < tau_pkg::VSIZE; k++) begin
					v.address[k] = lin + lane_step(c.id, k);
					v.valid[k]   = (o0 + k % s0 < c.bboundary[0]) &&
						(o1 + k / s0 < c.bboundary[1]);
				end
				exp_q.push_back(v);
				last_q.push_back(tile_end);
				o0  = o0 + s0;
				lin = lin + c.col_step;
			end
			// Next row starts from the row base
			row_base = row_base + c.row_step;
			o1       = o1 + s1;
		end
	endtask

	task automatic refresh_head();
		exp_avail = exp_q.size() > 0;
		exp_head  = exp_avail ? exp_q[0] : '0;
		exp_last  = exp_avail && last_q[0];
	endtask

	// ========================================
	// Stimulus
	// ========================================

	// Hold the command until its ack, seen mid-cycle
	task automatic send_cmd(input tau_pkg::cmd_t c);
		cmd     = c;
		cmd_rdy = 1'b1;
		do @(negedge clk); while (!cmd_ack);
		@(posedge clk);
		#1;
		cmd_rdy = 1'b0;
		cmd     = '0;
	endtask

	task automatic wait_vectors(input int target);
		while (n_vec < target) @(negedge clk);
		@(posedge clk);
		#1;
	endtask

	task automatic print_counts();
		$display("Counts: %0d vectors of %0d, %0d finish pulses, %0d assertion failures, %0d errors",
			n_vec, n_exp[N_CMD-1], n_fin, u_dut.u_chk.n_fail, err_cnt);
	endtask

	initial begin
		void'($urandom(32'h8ebb));
		cmd_rdy    = 1'b0;
		cmd        = '0;
		dst_ack    = 1'b0;
		ack_always = 1'b1;
		exp_issued = 0;
		n_acked    = 0;
		n_vec      = 0;
		n_fin      = 0;
		err_cnt    = 0;
		for (int c = 0; c < tau_pkg::N_CFG; c++) begin
			for (int j = 0; j < tau_pkg::CV_BW; j++) begin
				mofs_tab[c][j] = tau_pkg::addr_t'($urandom);
			end
		end
		for (int i = 0; i < N_CMD; i++) begin
			cmd_list[i] = make_cmd(i);
			build_reference(cmd_list[i]);
			n_exp[i] = exp_q.size();
		end
		for (int i = 0; i < ACK_PAT_LEN; i++) begin
			hold_pat[i] = ($urandom % 4 == 0);
		end
		refresh_head();
		@(posedge arst_n);
		@(posedge clk);
		#1;
		for (int i = 0; i < N_CMD; i++) begin
			// Drain the streaming phase before ack gaps start
			if (i == N_ALWAYS) begin
				wait_vectors(n_exp[i-1]);
				ack_always = 1'b0;
			end
			send_cmd(cmd_list[i]);
			repeat ($urandom % 3) begin
				@(posedge clk);
				#1;
			end
		end
		wait_vectors(n_exp[N_CMD-1]);
		// Room for surplus vectors or pulses to show
		repeat (8) @(negedge clk);
		assert (n_vec == n_exp[N_CMD-1]) else begin
			$display("Mismatch at time %0t: %0d vectors, expected %0d", $time,
				n_vec, n_exp[N_CMD-1]);
			err_cnt++;
		end
		assert (n_fin == N_CMD) else begin
			$display("Mismatch at time %0t: %0d finish pulses, expected %0d", $time,
				n_fin, N_CMD);
			err_cnt++;
		end
		print_counts();
		if (err_cnt == 0 && u_dut.u_chk.n_fail == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Ack one unit after the edge, with gaps from the pattern outside streaming
	initial begin
		ack_idx = 0;
		forever begin
			@(posedge clk);
			#1;
			dst_ack = arst_n && dst_rdy && (ack_always || !hold_pat[ack_idx]);
			ack_idx = (ack_idx + 1) % ACK_PAT_LEN;
		end
	end

	// Transfers taken on values settled in the cycle before the edge
	always @(posedge clk) begin
		if (arst_n && dst_rdy && dst_ack) begin
			n_vec++;
			if (fin_dval) begin
				n_fin++;
			end
			if (exp_q.size() > 0) begin
				void'(exp_q.pop_front());
				void'(last_q.pop_front());
			end
			refresh_head();
		end
	end

	// Warp total grows by the tile of each command taken
	always @(posedge clk) begin
		if (arst_n && cmd_ack && n_acked < N_CMD) begin
			exp_issued = n_exp[n_acked];
			n_acked++;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		print_counts();
		$display("Test FAILED");
		$finish;
	end

endmodule

//--- tb.f
tau_pkg.sv
rdyack_slice.sv
bofs_expand.sv
accum_warp_looper.sv
accum_warp_vector_stage.sv
accum_warp_top.sv
tb_clk_gen.sv
tb_accum_warp_chk.sv
tb_accum_warp.sv

//--- Bender.yml
package:
  name: accum_warp

sources:
  - tau_pkg.sv
  - rdyack_slice.sv
  - bofs_expand.sv
  - accum_warp_looper.sv
  - accum_warp_vector_stage.sv
  - accum_warp_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_accum_warp_chk.sv
      - tb_accum_warp.sv
